//--- sources.f
+incdir+verilog
verilog/fma_pkg.sv
verilog/fma_unpack.sv
verilog/fma_datapath.sv
verilog/fma_rounder.sv
verilog/fma_top.sv
bench/fma_checker.sv
bench/fma_tb.sv

//--- Makefile
SIM := obj_dir/Vfma_tb

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --assert -Wno-fatal --top-module fma_tb -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- bench/fma_testdata.txt
// a b c mode expected_result expected_flags, all hex, result = a*b+c
// flags: invalid overflow underflow inexact from bit 3 down
3fc00000 40000000 3e800000 0 40500000 0
3fc00000 40000000 c0300000 1 3e800000 0
3f800001 3f800001 00000000 0 3f800002 1
3f800001 3f800001 00000000 3 3f800003 1
bf800001 3f800001 00000000 2 bf800003 1
3f800000 3f800000 33800000 0 3f800000 1
3f800000 3f800000 33800000 4 3f800001 1
3f800000 3f800001 33800000 0 3f800002 1
3f800000 3f800000 33c00000 0 3f800001 1
3f800000 3f800000 33c00000 5 3f800000 1
7fc00000 3f800000 3f800000 0 7fc00000 8
00000000 7f800000 3f800000 0 7fc00000 8
7f800000 3f800000 ff800000 0 7fc00000 8
ff800000 40000000 3f800000 0 ff800000 0
7f000000 40000000 00000000 0 7f800000 5
7f000000 40000000 00000000 1 7f7fffff 5
ff000000 40000000 00000000 2 ff800000 5
ff000000 40000000 00000000 3 ff7fffff 5
1f800001 20000000 00000000 0 00400000 3
1f800001 20000000 00000000 4 00400001 3
3f800000 3f800000 bf800000 0 00000000 0
3f800000 3f800000 bf800000 2 80000000 0

//--- bench/fma_tb.sv
`timescale 1ns/1ps
`include "fma_defs.svh"

module fma_tb import fma_pkg::*; ();
    localparam int WORD_W       = 1 + `FMA_EXP_W + `FMA_MANT_W;
    localparam int REC_W        = 6;        // a, b, c, mode, result, flags
    localparam int MAX_VEC      = 64;
    localparam int ACK_TIMEOUT  = 20;
    localparam int DROP_TIMEOUT = 20;
    localparam int HOLD_CYCLES  = 2;        // Keep req_i high past ack

    logic               clk_i;
    logic               rst_i;
    logic               req_i;
    logic [WORD_W-1:0]  a_i;
    logic [WORD_W-1:0]  b_i;
    logic [WORD_W-1:0]  c_i;
    logic [2:0]         rm_i;
    logic               ack_o;
    logic [WORD_W-1:0]  result_o;
    logic [3:0]         flags_o;
    logic [WORD_W-1:0]  exp_result;
    logic [3:0]         exp_flags;
    logic [31:0]        vectors [MAX_VEC*REC_W];
    int                 vec_idx;
    int                 num_vec;
    int                 timeouts;
    int                 check_errors;
    int                 checked;
    bit                 ok;

    fma_top DUT (
        .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i),
        .a_i(a_i), .b_i(b_i), .c_i(c_i), .rm_i(rm_i),
        .ack_o(ack_o), .result_o(result_o), .flags_o(flags_o)
    );

    fma_checker u_check (
        .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_i(ack_o),
        .result_i(result_o), .flags_i(flags_o),
        .exp_result_i(exp_result), .exp_flags_i(exp_flags), .vec_i(vec_idx),
        .errors_o(check_errors), .checked_o(checked)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic load_vectors();
        for (int i = 0; i < MAX_VEC*REC_W; i++)
            vectors[i] = 32'hbad0_0000 | 32'(i);    // Mode word above 7 ends the list
        $readmemh("bench/fma_testdata.txt", vectors);
        num_vec = 0;
        while (num_vec < MAX_VEC && vectors[num_vec*REC_W+3] <= 32'd7)
            num_vec++;
    endtask

    ////////////////////
    // Four-phase driver
    task automatic run_vector(input int idx, output bit done);
        int          base;
        int          waited;
        round_mode_t mode;
        base = idx * REC_W;
        mode = round_mode_t'(vectors[base+3][2:0]);     // Codes 5 to 7 pass as read
        done = 1'b0;
        @(posedge clk_i);
        a_i        <= vectors[base];
        b_i        <= vectors[base+1];
        c_i        <= vectors[base+2];
        rm_i       <= mode;
        exp_result <= vectors[base+4];
        exp_flags  <= vectors[base+5][3:0];
        vec_idx    <= idx;
        req_i      <= 1'b1;
        waited = 0;
        @(negedge clk_i);
        while (!ack_o && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!ack_o) begin
            $display("Timeout: ack_o never rose within %0d cycles for vector %0d",
                     ACK_TIMEOUT, idx);
            timeouts++;
            return;
        end
        repeat (HOLD_CYCLES) @(posedge clk_i);
        req_i <= 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (ack_o && waited < DROP_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (ack_o) begin
            $display("Timeout: ack_o stayed high after req_i dropped for vector %0d", idx);
            timeouts++;
            return;
        end
        done = 1'b1;
    endtask

    task automatic finish_run();
        int failures;
        repeat (2) @(posedge clk_i);                    // Checker sees the last edges
        failures = check_errors + timeouts;
        if (num_vec == 0) begin
            $display("No test vectors were read from the data file");
            failures++;
        end else if (timeouts == 0 && checked != num_vec) begin
            $display("The checker compared %0d results for %0d vectors", checked, num_vec);
            failures++;
        end
        $display("Summary: %0d vectors, %0d checked, %0d check errors, %0d timeouts",
                 num_vec, checked, check_errors, timeouts);
        if (failures == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    initial begin
        rst_i      = 1'b1;
        req_i      = 1'b0;
        a_i        = '0;
        b_i        = '0;
        c_i        = '0;
        rm_i       = '0;
        exp_result = '0;
        exp_flags  = '0;
        vec_idx    = 0;
        timeouts   = 0;
        load_vectors();
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        ok = 1'b1;
        for (int i = 0; i < num_vec && ok; i++)
            run_vector(i, ok);
        finish_run();
    end

endmodule

//--- bench/fma_checker.sv
`timescale 1ns/1ps

module fma_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  logic        ack_i,
    input  logic [31:0] result_i,
    input  logic [3:0]  flags_i,
    input  logic [31:0] exp_result_i,
    input  logic [3:0]  exp_flags_i,
    input  int          vec_i,
    output int          errors_o,
    output int          checked_o
);
    localparam int ACK_LATENCY = 3;     // Edges from req seen to ack high

    logic   req_q   = 1'b0;
    logic   ack_q   = 1'b0;
    logic   rst_q   = 1'b1;
    logic   pending = 1'b0;
    int     edges   = 0;
    int     errors  = 0;
    int     checked = 0;

    assign errors_o  = errors;
    assign checked_o = checked;

    // Mid-cycle sampling, all DUT outputs settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            pending = 1'b0;
        end else begin
            if (rst_q && (ack_i || result_i != '0 || flags_i != '0)) begin
                errors++;
                $display("FAILED at %0t: outputs not cleared after reset", $time);
            end
            if (pending)
                edges++;
            if (req_i && !req_q && !ack_i) begin
                pending = 1'b1;             // New request
                edges   = 0;
            end

            ////////////////////
            // Result compare
            if (ack_i && !ack_q) begin
                checked++;
                if (!pending || edges != ACK_LATENCY) begin
                    errors++;
                    $display("FAILED at %0t: vector %0d ack_o rose after %0d edges, expected %0d",
                             $time, vec_i, edges, ACK_LATENCY);
                end
                if (result_i !== exp_result_i) begin
                    errors++;
                    $display("FAILED at %0t: vector %0d result %h, expected %h",
                             $time, vec_i, result_i, exp_result_i);
                end
                if (flags_i !== exp_flags_i) begin
                    errors++;
                    $display("FAILED at %0t: vector %0d flags %b, expected %b",
                             $time, vec_i, flags_i, exp_flags_i);
                end
                pending = 1'b0;
            end

            ////////////////////
            // Return to zero
            if (ack_q && !ack_i && req_q) begin
                errors++;
                $display("FAILED at %0t: vector %0d ack_o fell while req_i high", $time, vec_i);
            end
            if (ack_i && ack_q && !req_q) begin
                errors++;
                $display("FAILED at %0t: vector %0d ack_o held after req_i low", $time, vec_i);
            end
        end
        req_q = req_i;
        ack_q = ack_i;
        rst_q = rst_i;
    end

endmodule

//--- verilog/fma_top.sv
`timescale 1ns/1ps
`include "fma_defs.svh"

module fma_top import fma_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic [31:0] c_i,
    input  logic [2:0]  rm_i,
    output logic        ack_o,
    output logic [31:0] result_o,
    output logic [3:0]  flags_o
);
    localparam int EW = `FMA_EXP_W;
    localparam int MW = `FMA_MANT_W;

    logic [1:0]             phase;          // 0 idle, 1 datapath, 2 rounder
    logic                   start;
    logic [31:0]            a_q, b_q, c_q;
    logic [2:0]             rm_q;
    round_mode_t            rm_mode;
    logic                   a_sign, b_sign, c_sign;
    logic [EW-1:0]          a_exp, b_exp, c_exp;
    logic [MW:0]            a_sig, b_sig, c_sig;
    fp_class_t              a_class, b_class, c_class;
    logic                   dp_sign, dp_sticky, dp_zero;
    logic signed [EW+1:0]   dp_exp;
    logic [MW+2:0]          dp_sig;
    logic                   st_sign, st_sticky, st_zero;
    logic signed [EW+1:0]   st_exp;
    logic [MW+2:0]          st_sig;
    logic [31:0]            rnd_result;
    logic                   rnd_invalid, rnd_overflow, rnd_underflow, rnd_inexact;

    assign start   = (phase == 2'd0) && !ack_o && req_i;
    assign rm_mode = round_mode_t'(rm_q);

    ////////////////////
    // Handshake control
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase    <= 2'd0;
            ack_o    <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
        end else begin
            case (phase)
                2'd0: begin
                    if (start)
                        phase <= 2'd1;
                    if (ack_o && !req_i)
                        ack_o <= 1'b0;              // Return to zero
                end
                2'd1: phase <= 2'd2;
                2'd2: begin
                    phase    <= 2'd0;
                    ack_o    <= 1'b1;
                    result_o <= rnd_result;
                    flags_o  <= {rnd_invalid, rnd_overflow, rnd_underflow, rnd_inexact};
                end
                default: phase <= 2'd0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            a_q  <= a_i;
            b_q  <= b_i;
            c_q  <= c_i;
            rm_q <= rm_i;
        end
    end

    // Stage register between datapath and rounder
    always_ff @(posedge clk_i) begin
        if (phase == 2'd1) begin
            st_sign   <= dp_sign;
            st_exp    <= dp_exp;
            st_sig    <= dp_sig;
            st_sticky <= dp_sticky;
            st_zero   <= dp_zero;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i) $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose without a pending req_i");

    ////////////////////
    // Blocks
    fma_unpack u_unpack_a (.op_i(a_q), .sign_o(a_sign), .exp_o(a_exp),
                           .sig_o(a_sig), .class_o(a_class));
    fma_unpack u_unpack_b (.op_i(b_q), .sign_o(b_sign), .exp_o(b_exp),
                           .sig_o(b_sig), .class_o(b_class));
    fma_unpack u_unpack_c (.op_i(c_q), .sign_o(c_sign), .exp_o(c_exp),
                           .sig_o(c_sig), .class_o(c_class));

    // a_i times b_i forms the product, c_i goes to the addend ports
    fma_datapath u_datapath (
        .a_sign_i (c_sign),  .b_sign_i (a_sign),  .c_sign_i (b_sign),
        .a_exp_i  (c_exp),   .b_exp_i  (a_exp),   .c_exp_i  (b_exp),
        .a_sig_i  (c_sig),   .b_sig_i  (a_sig),   .c_sig_i  (b_sig),
        .b_class_i(a_class), .c_class_i(b_class), .rm_i     (rm_mode),
        .sign_o   (dp_sign), .exp_o    (dp_exp),  .sig_o    (dp_sig),
        .sticky_o (dp_sticky), .zero_o (dp_zero)
    );

    fma_rounder u_rounder (
        .sign_i   (st_sign), .exp_i    (st_exp),  .sig_i    (st_sig),
        .sticky_i (st_sticky), .zero_i (st_zero),
        .a_class_i(c_class), .b_class_i(a_class), .c_class_i(b_class),
        .a_sign_i (c_sign),  .b_sign_i (a_sign),  .c_sign_i (b_sign),
        .rm_i     (rm_mode), .result_o (rnd_result),
        .invalid_o(rnd_invalid), .overflow_o(rnd_overflow),
        .underflow_o(rnd_underflow), .inexact_o(rnd_inexact)
    );

endmodule

//--- verilog/fma_rounder.sv
`timescale 1ns/1ps
`include "fma_defs.svh"

module fma_rounder import fma_pkg::*; (
    input  logic                        sign_i,
    input  logic signed [`FMA_EXP_W+1:0] exp_i,
    input  logic [`FMA_MANT_W+2:0]      sig_i,
    input  logic                        sticky_i,
    input  logic                        zero_i,
    input  fp_class_t                   a_class_i,
    input  fp_class_t                   b_class_i,
    input  fp_class_t                   c_class_i,
    input  logic                        a_sign_i,
    input  logic                        b_sign_i,
    input  logic                        c_sign_i,
    input  round_mode_t                 rm_i,
    output logic [31:0]                 result_o,
    output logic                        invalid_o,
    output logic                        overflow_o,
    output logic                        underflow_o,
    output logic                        inexact_o
);
    localparam int EW = `FMA_EXP_W;
    localparam int MW = `FMA_MANT_W;
    localparam logic [EW-1:0] EXP_INF = '1;
    localparam logic [EW-1:0] EXP_TOP = EXP_INF - 1'b1;   // Largest finite

    logic                   any_nan;
    logic                   zero_mul_inf;
    logic                   inf_sub_inf;
    logic                   any_inf;
    logic                   inf_sign;
    logic [MW:0]            keep;
    logic                   guard;
    logic                   rnd;
    logic                   lost;
    logic                   round_up;
    logic [MW+1:0]          rounded;
    logic signed [EW+1:0]   exp_rnd;
    logic                   tiny;
    logic                   ovf;
    logic                   ovf_to_inf;
    logic [EW-1:0]          exp_field;
    logic [MW-1:0]          frac_field;

    assign any_nan      = a_class_i.is_nan | b_class_i.is_nan | c_class_i.is_nan;
    assign zero_mul_inf = (b_class_i.is_zero & c_class_i.is_inf)
                        | (c_class_i.is_zero & b_class_i.is_inf);
    assign inf_sub_inf  = a_class_i.is_inf & (b_class_i.is_inf | c_class_i.is_inf)
                        & (a_sign_i ^ b_sign_i ^ c_sign_i);
    assign any_inf      = a_class_i.is_inf | b_class_i.is_inf | c_class_i.is_inf;
    assign inf_sign     = a_class_i.is_inf ? a_sign_i : (b_sign_i ^ c_sign_i);

    assign keep  = sig_i[MW+2:2];
    assign guard = sig_i[1];
    assign rnd   = sig_i[0];
    assign lost  = guard | rnd | sticky_i;
    assign tiny  = (exp_i == 1) && !sig_i[MW+2];   // Before rounding

    ////////////////////
    // Rounding
    always_comb begin
        case (rm_i)
            rm_rne:  round_up = guard & (rnd | sticky_i | keep[0]);
            rm_rmm:  round_up = guard;
            rm_rup:  round_up = lost & ~sign_i;
            rm_rdn:  round_up = lost & sign_i;
            default: round_up = 1'b0;
        endcase
        case (rm_i)
            rm_rne, rm_rmm: ovf_to_inf = 1'b1;
            rm_rup:         ovf_to_inf = ~sign_i;
            rm_rdn:         ovf_to_inf = sign_i;
            default:        ovf_to_inf = 1'b0;
        endcase
    end

    assign rounded = {1'b0, keep} + round_up;
    assign exp_rnd = rounded[MW+1] ? exp_i + 1 : exp_i;   // Carry renormalizes
    assign ovf     = (exp_rnd >= 255);

    // Denormal that rounds up into bit MW becomes the smallest normal
    assign exp_field  = (rounded[MW+1] | rounded[MW]) ? exp_rnd[EW-1:0] : '0;
    assign frac_field = rounded[MW+1] ? rounded[MW:1] : rounded[MW-1:0];

    ////////////////////
    // Result select
    always_comb begin
        invalid_o   = 1'b0;
        overflow_o  = 1'b0;
        underflow_o = 1'b0;
        inexact_o   = 1'b0;
        result_o    = '0;
        if (any_nan | zero_mul_inf | inf_sub_inf) begin
            invalid_o = 1'b1;
            result_o  = {1'b0, EXP_INF, `FMA_QNAN_MANT};
        end else if (any_inf) begin
            result_o = {inf_sign, EXP_INF, {MW{1'b0}}};       // Exact result without flags
        end else if (zero_i) begin
            result_o = {sign_i, {(EW+MW){1'b0}}};
        end else if (ovf) begin
            overflow_o = 1'b1;
            inexact_o  = 1'b1;
            if (ovf_to_inf)
                result_o = {sign_i, EXP_INF, {MW{1'b0}}};
            else
                result_o = {sign_i, EXP_TOP, {MW{1'b1}}};
        end else begin
            inexact_o   = lost;
            underflow_o = tiny & lost;
            result_o    = {sign_i, exp_field, frac_field};
        end
        // Datapath leaves the hidden bit clear only at exponent 1
        assert (zero_i || exp_i <= 1 || sig_i[MW+2])
            else $error("significand not normalized at exponent %0d", exp_i);
    end

endmodule

//--- verilog/fma_datapath.sv
`timescale 1ns/1ps
`include "fma_defs.svh"

module fma_datapath import fma_pkg::*; (
    input  logic                        a_sign_i,
    input  logic                        b_sign_i,
    input  logic                        c_sign_i,
    input  logic [`FMA_EXP_W-1:0]       a_exp_i,
    input  logic [`FMA_EXP_W-1:0]       b_exp_i,
    input  logic [`FMA_EXP_W-1:0]       c_exp_i,
    input  logic [`FMA_MANT_W:0]        a_sig_i,
    input  logic [`FMA_MANT_W:0]        b_sig_i,
    input  logic [`FMA_MANT_W:0]        c_sig_i,
    input  fp_class_t                   b_class_i,
    input  fp_class_t                   c_class_i,
    input  round_mode_t                 rm_i,
    output logic                        sign_o,
    output logic signed [`FMA_EXP_W+1:0] exp_o,
    output logic [`FMA_MANT_W+2:0]      sig_o,
    output logic                        sticky_o,
    output logic                        zero_o
);
    localparam int EW   = `FMA_EXP_W;
    localparam int SW   = `FMA_MANT_W + 1;  // Significand with hidden bit
    localparam int PW   = 2 * SW;
    localparam int FW   = 3 * SW + 4;       // 76 bit alignment field
    localparam int XW   = EW + 3;
    localparam int LZW  = $clog2(FW + 1);
    localparam int BIAS = `FMA_BIAS;

    logic [PW-1:0]          prod;
    logic                   prod_sign;
    logic                   prod_zero;
    logic                   eff_sub;
    logic signed [XW-1:0]   prod_exp;
    logic signed [XW-1:0]   exp_diff;
    logic signed [XW-1:0]   exp_gap;
    logic signed [XW-1:0]   big_exp;
    logic signed [XW-1:0]   shift_lim;
    logic signed [XW-1:0]   exp_norm;
    logic [FW-1:0]          prod_field;
    logic [FW-1:0]          add_field;
    logic [FW-1:0]          big_field;
    logic [FW-1:0]          small_field;
    logic [FW-1:0]          small_al;
    logic [FW-1:0]          lost;
    logic [FW-1:0]          mag;
    logic [FW-1:0]          norm;
    logic [FW:0]            diff;
    logic [LZW-1:0]         shift_amt;
    logic [LZW-1:0]         lz;
    logic [LZW-1:0]         norm_shift;
    logic                   big_sign;
    logic                   neg;

    assign prod      = b_sig_i * c_sig_i;
    assign prod_sign = b_sign_i ^ c_sign_i;
    assign prod_zero = b_class_i.is_zero | c_class_i.is_zero;
    assign prod_exp  = $signed(XW'(b_exp_i)) + $signed(XW'(c_exp_i)) - $signed(XW'(BIAS));
    assign eff_sub   = prod_sign ^ a_sign_i;

    // Bit FW-3 carries weight 2^(exp - bias) for either operand
    assign prod_field = {1'b0, prod, {(FW-PW-1){1'b0}}};
    assign add_field  = {2'b00, a_sig_i, {(FW-SW-2){1'b0}}};

    ////////////////////
    // Alignment
    always_comb begin
        exp_diff = prod_exp - $signed(XW'(a_exp_i));
        if (!prod_zero && !exp_diff[XW-1]) begin
            big_field   = prod_field;
            big_sign    = prod_sign;
            big_exp     = prod_exp;
            small_field = add_field;
            exp_gap     = exp_diff;
        end else begin
            big_field   = add_field;
            big_sign    = a_sign_i;
            big_exp     = $signed(XW'(a_exp_i));
            small_field = prod_zero ? '0 : prod_field;  // Zero product adds nothing
            exp_gap     = -exp_diff;
        end
        if (exp_gap > $signed(XW'(FW)))
            shift_amt = LZW'(FW);
        else
            shift_amt = LZW'(exp_gap);
        {small_al, lost} = {small_field, {FW{1'b0}}} >> shift_amt;
        small_al[0] = small_al[0] | (|lost);           // Jam shifted-out bits
    end

    ////////////////////
    // Add or subtract
    always_comb begin
        if (eff_sub)
            diff = {1'b0, big_field} - {1'b0, small_al};
        else
            diff = {1'b0, big_field} + {1'b0, small_al};
        neg = eff_sub & diff[FW];
        mag = neg ? -diff[FW-1:0] : diff[FW-1:0];
    end

    ////////////////////
    // Normalize
    always_comb begin
        lz = LZW'(FW);
        for (int i = 0; i < FW; i++) begin
            if (mag[i])
                lz = LZW'(FW - 1 - i);
        end
        // Stop at exponent 1, tiny results stay denormal
        shift_lim = big_exp + $signed(XW'(1));
        if ($signed(XW'(lz)) > shift_lim)
            norm_shift = LZW'(shift_lim);
        else
            norm_shift = lz;
        norm     = mag << norm_shift;
        exp_norm = big_exp + $signed(XW'(2)) - $signed(XW'(norm_shift));
    end

    assign exp_o    = exp_norm[EW+1:0];
    assign sig_o    = norm[FW-1 -: SW+2];
    assign sticky_o = |norm[FW-SW-3:0];
    assign zero_o   = (mag == '0);

    // Exact zero: shared sign if both terms agree, else -0 only rounding down
    always_comb begin
        if (!zero_o)
            sign_o = big_sign ^ neg;
        else if (!eff_sub)
            sign_o = a_sign_i;
        else
            sign_o = (rm_i == rm_rdn);
    end

endmodule

//--- verilog/fma_unpack.sv
`timescale 1ns/1ps
`include "fma_defs.svh"

module fma_unpack import fma_pkg::*; (
    input  logic [31:0]             op_i,
    output logic                    sign_o,
    output logic [`FMA_EXP_W-1:0]   exp_o,
    output logic [`FMA_MANT_W:0]    sig_o,
    output fp_class_t               class_o
);
    logic [`FMA_EXP_W-1:0]  exp_field;
    logic [`FMA_MANT_W-1:0] frac_field;
    logic                   exp_zero;
    logic                   exp_ones;
    logic                   frac_zero;

    assign sign_o     = op_i[31];
    assign exp_field  = op_i[`FMA_EXP_W+`FMA_MANT_W-1:`FMA_MANT_W];
    assign frac_field = op_i[`FMA_MANT_W-1:0];

    assign exp_zero  = (exp_field == '0);
    assign exp_ones  = (exp_field == '1);
    assign frac_zero = (frac_field == '0);

    // Denormal reads as exponent 1, hidden bit cleared
    assign exp_o = exp_zero ? {{(`FMA_EXP_W-1){1'b0}}, 1'b1} : exp_field;
    assign sig_o = {~exp_zero, frac_field};

    assign class_o.is_nan    = exp_ones & ~frac_zero;
    assign class_o.is_inf    = exp_ones & frac_zero;
    assign class_o.is_zero   = exp_zero & frac_zero;
    assign class_o.is_denorm = exp_zero & ~frac_zero;

endmodule

//--- verilog/fma_pkg.sv
package fma_pkg;

    // Rounding modes, codes 5 to 7 behave as rm_rtz
    typedef enum logic [2:0] {
        rm_rne = 3'd0,              // Nearest, ties to even
        rm_rtz = 3'd1,              // Toward zero
        rm_rdn = 3'd2,              // Toward minus infinity
        rm_rup = 3'd3,              // Toward plus infinity
        rm_rmm = 3'd4               // Nearest, ties away
    } round_mode_t;

    // Operand class
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic is_zero;
        logic is_denorm;
    } fp_class_t;

endpackage

//--- verilog/fma_defs.svh
`ifndef FMA_DEFS_SVH
`define FMA_DEFS_SVH

// binary32 field widths
`define FMA_EXP_W       8
`define FMA_MANT_W      23
`define FMA_BIAS        127

// Canonical quiet NaN fraction
`define FMA_QNAN_MANT   23'h40_0000

`endif
